// ==== design/pu_adder.sv ====
module pu_adder #(
    parameter int invalid = 0
) (
    input  logic            clk,
    input  logic            rst,
    input  pu_pkg::pu_in_t  bus_in,
    output pu_pkg::pu_out_t bus_out
);

    localparam int msb = pu_pkg::data_width - 1;

    logic [pu_pkg::data_width-1:0] arg [2];
    logic                          arg_inv [2];
    logic                          sel_q;
    logic                          commit;
    logic [pu_pkg::data_width-1:0] sum;
    logic                          overflow;
    logic [pu_pkg::data_width-1:0] result;
    logic                          result_inv;

    always_ff @(posedge clk) begin
        if (rst) begin
            arg[0]     <= '0;
            arg[1]     <= '0;
            arg_inv[0] <= 1'b0;
            arg_inv[1] <= 1'b0;
        end else if (bus_in.wr) begin
            arg[bus_in.sel]     <= bus_in.data;
            arg_inv[bus_in.sel] <= bus_in.attr[invalid];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q  <= 1'b0;
            commit <= 1'b0;
        end else begin
            sel_q  <= bus_in.sel;
            commit <= sel_q && !bus_in.sel;  // one cycle after sel falls.
        end
    end

    // operands of one sign whose sum has the other sign have overflowed.
    always_comb begin
        sum      = arg[0] + arg[1];
        overflow = (arg[0][msb] == arg[1][msb]) && (sum[msb] != arg[0][msb]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result     <= '0;
            result_inv <= 1'b0;
        end else if (commit) begin
            result     <= sum;
            result_inv <= arg_inv[0] || arg_inv[1] || overflow;
        end
    end

    always_comb begin
        bus_out = '0;
        if (bus_in.oe) begin
            bus_out.data          = result;
            bus_out.attr[invalid] = result_inv;
        end
    end

endmodule

// ==== design/pu_axi_bridge.sv ====
module pu_axi_bridge (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pu_pkg::addr_width-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [pu_pkg::data_width-1:0] wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [pu_pkg::addr_width-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [pu_pkg::data_width-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output pu_pkg::pu_in_t                mult_in,
    output pu_pkg::pu_in_t                add_in,
    input  pu_pkg::pu_out_t               mult_out,
    input  pu_pkg::pu_out_t               add_out
);

    localparam logic [1:0] resp_okay = 2'b00;

    pu_pkg::bridge_state_e         state;
    pu_pkg::bridge_state_e         state_next;
    logic                          ready;
    logic                          wr_hs;
    logic                          rd_hs;
    pu_pkg::reg_op_e               wr_op;
    pu_pkg::reg_op_e               rd_op;
    logic                          wr_mapped;
    logic                          rd_mapped;
    logic [pu_pkg::data_width-1:0] wr_data;
    logic                          wr_add;
    logic                          wr_idx;
    logic                          wr_inv;
    logic                          settle_cnt;
    logic                          rd_mult_oe;
    logic                          rd_add_oe;
    logic                          rd_attr;
    logic [pu_pkg::data_width-1:0] merged_data;
    logic [pu_pkg::attr_width-1:0] merged_attr;

    assign wr_hs   = ready && awvalid && wvalid;  // address and data are taken together.
    assign rd_hs   = ready && arvalid && !(awvalid && wvalid);
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign arready = rd_hs;
    assign bvalid  = (state == pu_pkg::st_wresp);
    assign rvalid  = (state == pu_pkg::st_rdata);
    assign bresp   = resp_okay;
    assign rresp   = resp_okay;

    assign wr_idx = wr_op inside {pu_pkg::op_mult_b, pu_pkg::op_add_b,
                                  pu_pkg::op_mult_b_inv, pu_pkg::op_add_b_inv};
    assign wr_add = wr_op inside {pu_pkg::op_add_a, pu_pkg::op_add_b,
                                  pu_pkg::op_add_a_inv, pu_pkg::op_add_b_inv};
    assign wr_inv = wr_op inside {pu_pkg::op_mult_a_inv, pu_pkg::op_mult_b_inv,
                                  pu_pkg::op_add_a_inv, pu_pkg::op_add_b_inv};

    assign rd_op     = pu_pkg::reg_op_e'({araddr[5:2], 2'b00});
    assign rd_mapped = (araddr[pu_pkg::addr_width-1:6] == '0);

    // oe is raised in the handshake cycle so rdata can be captured at its end.
    always_comb begin
        rd_mult_oe = 1'b0;
        rd_add_oe  = 1'b0;
        rd_attr    = 1'b0;
        if (rd_hs && rd_mapped) begin
            case (rd_op)
                pu_pkg::op_mult_a: rd_mult_oe = 1'b1;
                pu_pkg::op_mult_b: begin
                    rd_mult_oe = 1'b1;
                    rd_attr    = 1'b1;
                end
                pu_pkg::op_add_a: rd_add_oe = 1'b1;
                pu_pkg::op_add_b: begin
                    rd_add_oe = 1'b1;
                    rd_attr   = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign merged_data = mult_out.data | add_out.data;  // only one unit has oe high.
    assign merged_attr = mult_out.attr | add_out.attr;

    always_comb begin
        mult_in      = '0;
        add_in       = '0;
        mult_in.data = wr_data;
        add_in.data  = wr_data;
        mult_in.attr = {pu_pkg::attr_width{wr_inv}};
        add_in.attr  = {pu_pkg::attr_width{wr_inv}};
        if (state == pu_pkg::st_strobe && wr_mapped) begin
            if (wr_add) begin
                add_in.wr  = 1'b1;
                add_in.sel = wr_idx;
            end else begin
                mult_in.wr  = 1'b1;
                mult_in.sel = wr_idx;
            end
        end
        mult_in.oe = rd_mult_oe;
        add_in.oe  = rd_add_oe;
    end

    always_comb begin
        state_next = state;
        case (state)
            pu_pkg::st_idle: begin
                if (wr_hs) state_next = pu_pkg::st_strobe;
                else if (rd_hs) state_next = pu_pkg::st_rdata;
            end
            pu_pkg::st_strobe:  state_next = pu_pkg::st_release;
            pu_pkg::st_release: state_next = wr_idx ? pu_pkg::st_settle : pu_pkg::st_wresp;
            pu_pkg::st_settle:  if (settle_cnt) state_next = pu_pkg::st_wresp;
            pu_pkg::st_wresp:   if (bready) state_next = pu_pkg::st_idle;
            pu_pkg::st_rdata:   if (rready) state_next = pu_pkg::st_idle;
            default:            state_next = pu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= pu_pkg::st_idle;
            ready      <= 1'b0;
            settle_cnt <= 1'b0;
        end else begin
            state      <= state_next;
            ready      <= (state_next == pu_pkg::st_idle);
            settle_cnt <= (state == pu_pkg::st_settle) && !settle_cnt;  // two settle cycles.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            wr_op     <= pu_pkg::reg_op_e'({awaddr[5:2], 2'b00});
            wr_mapped <= (awaddr[pu_pkg::addr_width-1:5] == '0);
            wr_data   <= wdata;
        end
        if (rd_hs) begin
            rdata <= rd_attr ? {{(pu_pkg::data_width-pu_pkg::attr_width){1'b0}}, merged_attr}
                             : merged_data;
        end
    end

endmodule

// ==== design/pu_multiplier.sv ====
module pu_multiplier #(
    parameter int scaling_factor_power = 0,
    parameter int invalid              = 0
) (
    input  logic            clk,
    input  logic            rst,
    input  pu_pkg::pu_in_t  bus_in,
    output pu_pkg::pu_out_t bus_out
);

    localparam int half = pu_pkg::data_width / 2;

    logic [pu_pkg::data_width-1:0]        arg [2];
    logic                                 arg_inv [2];
    logic                                 sel_q;
    logic                                 commit;
    logic signed [pu_pkg::data_width-1:0] product;
    logic                                 overflow;
    logic [pu_pkg::data_width-1:0]        result;
    logic                                 result_inv;

    // true when the value is a sign extension of its low half.
    function automatic logic fits_half(input logic [pu_pkg::data_width-1:0] v);
        logic [half:0] upper;
        upper = v[pu_pkg::data_width-1:half-1];
        return (&upper) || !(|upper);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            arg[0]     <= '0;
            arg[1]     <= '0;
            arg_inv[0] <= 1'b0;
            arg_inv[1] <= 1'b0;
        end else if (bus_in.wr) begin
            arg[bus_in.sel]     <= bus_in.data;
            arg_inv[bus_in.sel] <= bus_in.attr[invalid];
        end
    end

    // a falling sel commits and the pulse comes one cycle after the fall.
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q  <= 1'b0;
            commit <= 1'b0;
        end else begin
            sel_q  <= bus_in.sel;
            commit <= sel_q && !bus_in.sel;
        end
    end

    always_comb begin
        product  = $signed(arg[0][half-1:0]) * $signed(arg[1][half-1:0]);
        overflow = !fits_half(arg[0]) || !fits_half(arg[1]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result     <= '0;
            result_inv <= 1'b0;
        end else if (commit) begin
            result     <= product >>> scaling_factor_power;  // keeps the sign of the product.
            result_inv <= arg_inv[0] || arg_inv[1] || overflow;
        end
    end

    always_comb begin
        bus_out = '0;
        if (bus_in.oe) begin
            bus_out.data          = result;
            bus_out.attr[invalid] = result_inv;
        end
    end

endmodule

// ==== design/pu_pkg.sv ====
package pu_pkg;

    localparam int data_width = 32;
    localparam int attr_width = 4;
    localparam int addr_width = 8;

    // the values are byte addresses and only bits [5:2] take part in the decode.
    typedef enum logic [5:0] {
        op_mult_a     = 6'h00,
        op_mult_b     = 6'h04,
        op_add_a      = 6'h08,
        op_add_b      = 6'h0C,
        op_mult_a_inv = 6'h10,
        op_mult_b_inv = 6'h14,
        op_add_a_inv  = 6'h18,
        op_add_b_inv  = 6'h1C
    } reg_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_strobe,
        st_release,
        st_settle,
        st_wresp,
        st_rdata
    } bridge_state_e;

    typedef struct packed {
        logic                  wr;   // argument write strobe.
        logic                  sel;  // argument index whose fall commits the operation.
        logic [data_width-1:0] data;
        logic [attr_width-1:0] attr;
        logic                  oe;
    } pu_in_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [attr_width-1:0] attr;
    } pu_out_t;

endpackage

// ==== design/pu_subsystem.sv ====
module pu_subsystem #(
    parameter int scaling_factor_power = 0,
    parameter int invalid              = 0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pu_pkg::addr_width-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [pu_pkg::data_width-1:0] wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [pu_pkg::addr_width-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [pu_pkg::data_width-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    pu_pkg::pu_in_t  mult_in;
    pu_pkg::pu_in_t  add_in;
    pu_pkg::pu_out_t mult_out;
    pu_pkg::pu_out_t add_out;

    pu_axi_bridge u_bridge (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .mult_in  (mult_in),
        .add_in   (add_in),
        .mult_out (mult_out),
        .add_out  (add_out)
    );

    pu_multiplier #(
        .scaling_factor_power (scaling_factor_power),
        .invalid              (invalid)
    ) u_mult (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (mult_in),
        .bus_out (mult_out)
    );

    pu_adder #(
        .invalid (invalid)
    ) u_add (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (add_in),
        .bus_out (add_out)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module pu_subsystem_tb -f sim.f \
    && ./obj_dir/Vpu_subsystem_tb | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
design/pu_pkg.sv
design/pu_multiplier.sv
design/pu_adder.sv
design/pu_axi_bridge.sv
design/pu_subsystem.sv
tests/pu_bridge_checker.sv
tests/pu_subsystem_tb.sv

// ==== tests/pu_bridge_checker.sv ====
module pu_bridge_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          awready,
    input logic                          wready,
    input logic                          arready,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          rvalid,
    input logic                          rready,
    input logic [pu_pkg::data_width-1:0] rdata,
    input pu_pkg::pu_in_t                mult_in,
    input pu_pkg::pu_in_t                add_in
);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    // read data must not move while the host stalls the R channel.
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped or rdata changed before rready was seen");

    a_wr_not_oe: assert property (@(posedge clk) disable iff (rst)
        !(mult_in.wr && mult_in.oe) && !(add_in.wr && add_in.oe))
        else $error("a unit saw wr and oe high together");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !awready && !wready && !arready && !bvalid && !rvalid
            && !mult_in.wr && !mult_in.sel && !mult_in.oe
            && !add_in.wr && !add_in.sel && !add_in.oe)
        else $error("bridge outputs not low after reset");

endmodule

bind pu_axi_bridge pu_bridge_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .mult_in (mult_in),
    .add_in  (add_in)
);

// ==== tests/pu_subsystem_tb.sv ====
module pu_subsystem_tb;

    localparam int timeout_cycles = 50;
    localparam int hold_cycles    = 4;
    localparam int scale          = 4;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic        a_inv;
        logic        b_inv;
        logic [31:0] prod;
        logic        prod_inv;
        logic [31:0] sum;
        logic        sum_inv;
    } entry_t;

    logic        clk;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int     errors;
    int     checks;
    int     tests;
    int     seed;
    bit     timed_out;
    entry_t rand_entry;

    // a, b, a_inv, b_inv, product >>> 4, product invalid, sum, sum invalid.
    entry_t directed [10] = '{
        '{32'h0000_0064, 32'h0000_0007, 1'b0, 1'b0, 32'h0000_002B, 1'b0, 32'h0000_006B, 1'b0},
        '{32'hFFFF_FF9C, 32'h0000_0007, 1'b0, 1'b0, 32'hFFFF_FFD4, 1'b0, 32'hFFFF_FFA3, 1'b0},
        '{32'hFFFF_FED4, 32'hFFFF_FFEC, 1'b0, 1'b0, 32'h0000_0177, 1'b0, 32'hFFFF_FEC0, 1'b0},
        '{32'h0001_0002, 32'h0000_0040, 1'b0, 1'b0, 32'h0000_0008, 1'b1, 32'h0001_0042, 1'b0},
        '{32'h0000_8000, 32'h0000_0002, 1'b0, 1'b0, 32'hFFFF_F000, 1'b1, 32'h0000_8002, 1'b0},
        '{32'h0000_000A, 32'h0000_0014, 1'b1, 1'b0, 32'h0000_000C, 1'b1, 32'h0000_001E, 1'b1},
        '{32'hFFFF_FFF8, 32'h0000_0040, 1'b0, 1'b1, 32'hFFFF_FFE0, 1'b1, 32'h0000_0038, 1'b1},
        '{32'h7FFF_FFFF, 32'h0000_0001, 1'b0, 1'b0, 32'hFFFF_FFFF, 1'b1, 32'h8000_0000, 1'b1},
        '{32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0, 32'h0000_0000, 1'b1, 32'h7FFF_FFFF, 1'b1},
        '{32'h0000_04D2, 32'hFFFF_FFC8, 1'b0, 1'b0, 32'hFFFF_EF21, 1'b0, 32'h0000_049A, 1'b0}
    };

    // only b changes and a stays 0x4D2 from the last directed entry.
    entry_t rewrite = '{32'h0000_04D2, 32'h0000_000A, 1'b0, 1'b0,
                        32'h0000_0303, 1'b0, 32'h0000_04DC, 1'b0};

    pu_subsystem #(
        .scaling_factor_power (scale),
        .invalid              (0)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic entry_t model_entry(input logic [31:0] a, input logic [31:0] b,
                                           input logic a_inv, input logic b_inv);
        entry_t e;
        longint sa;
        longint sb;
        longint p;
        longint s;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        p  = longint'($signed(a[15:0])) * longint'($signed(b[15:0]));
        p  = p >>> scale;
        s  = sa + sb;
        e.a        = a;
        e.b        = b;
        e.a_inv    = a_inv;
        e.b_inv    = b_inv;
        e.prod     = p[31:0];
        e.prod_inv = a_inv || b_inv || sa < -64'sd32768 || sa > 64'sd32767
                     || sb < -64'sd32768 || sb > 64'sd32767;
        e.sum      = s[31:0];
        e.sum_inv  = a_inv || b_inv || s > 64'sd2147483647 || s < -64'sd2147483648;
        return e;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %s did not arrive within %0d cycles", what, timeout_cycles);
        timed_out = 1'b1;
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold);
        int waited;
        bit seen;
        if (timed_out) return;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        seen    = 1'b0;
        while (!seen && waited < timeout_cycles) begin
            @(posedge clk);
            seen = awready && wready;  // inputs have been stable since the negedge.
            waited++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!seen) begin
            report_timeout("write address and data handshake");
            return;
        end
        waited = 0;
        while (!bvalid && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!bvalid) begin
            report_timeout("write response");
            return;
        end
        checks++;
        assert (bresp == 2'b00) else begin
            $display("mismatch at %0t: bresp %b on write to 0x%h", $time, bresp, addr);
            errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (bvalid) else begin
                $display("mismatch at %0t: bvalid dropped while bready was low", $time);
                errors++;
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int waited;
        bit seen;
        data = '0;
        resp = '0;
        if (timed_out) return;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        seen    = 1'b0;
        while (!seen && waited < timeout_cycles) begin
            @(posedge clk);
            seen = arready;
            waited++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (!seen) begin
            report_timeout("read address handshake");
            return;
        end
        waited = 0;
        while (!rvalid && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!rvalid) begin
            report_timeout("read data");
            return;
        end
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (rvalid && rdata == data) else begin
                $display("mismatch at %0t: read response changed while rready was low", $time);
                errors++;
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] expected,
                              input string what, input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, hold, data, resp);
        if (timed_out) return;
        checks += 2;
        assert (data == expected) else begin
            $display("mismatch at %0t: %s at 0x%h read %h, expected %h",
                     $time, what, addr, data, expected);
            errors++;
        end
        assert (resp == 2'b00) else begin
            $display("mismatch at %0t: rresp %b at 0x%h", $time, resp, addr);
            errors++;
        end
    endtask

    // both units get the same arguments with arg 0 first so that arg 1 commits.
    task automatic apply_entry(input int idx, input entry_t e, input bit write_a, input int hold);
        int errors_before;
        errors_before = errors;
        if (write_a) begin
            axi_write(e.a_inv ? 8'h10 : 8'h00, e.a, 0);
            axi_write(e.a_inv ? 8'h18 : 8'h08, e.a, 0);
        end
        axi_write(e.b_inv ? 8'h14 : 8'h04, e.b, hold);
        axi_write(e.b_inv ? 8'h1C : 8'h0C, e.b, hold);
        check_read(8'h00, e.prod, "product", hold);
        check_read(8'h04, {31'b0, e.prod_inv}, "product attribute", 0);
        check_read(8'h08, e.sum, "sum", hold);
        check_read(8'h0C, {31'b0, e.sum_inv}, "sum attribute", 0);
        tests++;
        if (!timed_out) begin
            $display("test %0d a=%h b=%h: %0d errors", idx, e.a, e.b, errors - errors_before);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        int          errors_before;
        rst       = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        seed      = 32'hbc6b;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 10; i++) begin
            apply_entry(i, directed[i], 1'b1, 0);
        end
        apply_entry(10, rewrite, 1'b0, hold_cycles);  // rewrites arg 1 with B and R stalled.

        errors_before = errors;
        check_read(8'h14, 32'h0, "unmapped read", 0);
        check_read(8'h40, 32'h0, "unmapped read", hold_cycles);
        tests++;
        if (!timed_out) begin
            $display("test 11 unmapped reads: %0d errors", errors - errors_before);
        end

        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            a = {{16{r[15]}}, r[15:0]};
            r = $random(seed);
            b = {{16{r[15]}}, r[15:0]};
            r = $random(seed);
            rand_entry = model_entry(a, b, r[0], r[1]);
            apply_entry(12 + i, rand_entry, 1'b1, 0);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
